/* alu_top.f */
+incdir+hw
hw/alu_op_pkg.sv
hw/alu_data_pkg.sv
hw/alu_decoder.sv
hw/alu_adder.sv
hw/alu_shifter.sv
hw/ldpc_unit.sv
hw/alu_result_stage.sv
hw/alu_top.sv
dv/alu_assert.sv
dv/alu_tb.sv

/* dv/alu_assert.sv */
`default_nettype none

module alu_assert (
  input logic                   clk_i,
  input logic                   arst_n_i,
  input logic                   valid_i,
  input alu_op_pkg::alu_ctrl_t  ctrl_i,
  input logic                   valid_out_i,
  input alu_data_pkg::alu_rsp_t rsp_i
);

  // Response valid trails the strobe by exactly one cycle
  valid_follows_strobe: assert property (
    @(posedge clk_i) disable iff (!arst_n_i)
      valid_out_i == $past(valid_i)
  ) else $error("valid_o is not the valid_i of the previous cycle");

  valid_low_in_reset: assert property (
    @(posedge clk_i) !arst_n_i |-> !valid_out_i
  ) else $error("valid_o is high while reset is active");

  // Non-branch ops always report a taken branch
  branch_none_taken: assert property (
    @(posedge clk_i) disable iff (!arst_n_i)
      (valid_i && ctrl_i.branch_cond == alu_op_pkg::BR_NONE) |=> rsp_i.branch_res
  ) else $error("branch_res is low for an operation without a branch condition");

endmodule

`default_nettype wire

/* dv/alu_tb.sv */
`default_nettype none

`include "alu_consts.svh"

module alu_tb;

  localparam int PERIOD            = 100;
  localparam int N_TESTS           = 5;
  localparam int MAX_STROBES       = 100;
  localparam int CYCLES_PER_STROBE = 2;
  localparam int MARGIN_CYCLES     = 66;
  localparam int TIMEOUT = (N_TESTS * MAX_STROBES * CYCLES_PER_STROBE + MARGIN_CYCLES) * PERIOD;

  logic                   clk_i = 1'b0;
  logic                   arst_n_i;
  logic                   req_valid_i;
  alu_data_pkg::alu_req_t req_i;
  logic                   rsp_valid_o;
  alu_data_pkg::alu_rsp_t rsp_o;

  logic [15:0] lfsr_state = 16'd10392;
  int          error_count = 0;
  int          check_count = 0;
  int          test_start_errors = 0;

  alu_top uut (
    .clk_i       (clk_i),
    .arst_n_i    (arst_n_i),
    .req_valid_i (req_valid_i),
    .req_i       (req_i),
    .rsp_valid_o (rsp_valid_o),
    .rsp_o       (rsp_o)
  );

  bind alu_result_stage alu_assert u_assert (
    .clk_i       (clk_i),
    .arst_n_i    (arst_n_i),
    .valid_i     (valid_i),
    .ctrl_i      (ctrl_i),
    .valid_out_i (valid_o),
    .rsp_i       (rsp_o)
  );

  always #(PERIOD / 2) clk_i = ~clk_i;

  // ------------------------------
  // Random source
  // ------------------------------
  // Taps at x^16+x^14+x^13+x^11
  function automatic logic [15:0] lfsr_next(input logic [15:0] s);
    return {s[14:0], s[15] ^ s[13] ^ s[12] ^ s[10]};
  endfunction

  function logic [`ALU_XLEN-1:0] rand32();
    logic [`ALU_XLEN-1:0] v;
    v = '0;
    for (int i = 0; i < `ALU_XLEN; i++) begin
      lfsr_state = lfsr_next(lfsr_state);
      v = {v[`ALU_XLEN-2:0], lfsr_state[0]};
    end
    return v;
  endfunction

  function automatic int sat127(input int v);
    if (v > 127) begin
      return 127;
    end
    if (v < -127) begin
      return -127;
    end
    return v;
  endfunction

  // ------------------------------
  // Reference model
  // ------------------------------
  function automatic alu_data_pkg::alu_rsp_t expected_rsp(input alu_op_pkg::alu_op_e op,
      input logic [31:0] a, input logic [31:0] b, input logic [31:0] c);
    alu_data_pkg::alu_rsp_t r;
    int sa;
    int sb;
    int sc;
    int t;
    r.result     = '0;
    r.branch_res = 1'b1;
    sa = $signed(a[7:0]);
    sb = $signed(b[7:0]);
    sc = $signed(c[7:0]);
    t  = 0;
    case (op)
      alu_op_pkg::ADD:  r.result = a + b;
      alu_op_pkg::SUB:  r.result = a - b;
      alu_op_pkg::ANDL: r.result = a & b;
      alu_op_pkg::ORL:  r.result = a | b;
      alu_op_pkg::XORL: r.result = a ^ b;
      alu_op_pkg::ANDN: r.result = a & ~b;
      alu_op_pkg::ORN:  r.result = a | ~b;
      alu_op_pkg::XNOR: r.result = ~(a ^ b);
      alu_op_pkg::SLL:  r.result = a << b[4:0];
      alu_op_pkg::SRL:  r.result = a >> b[4:0];
      alu_op_pkg::SRA:  r.result = $signed(a) >>> b[4:0];
      alu_op_pkg::SLTS: r.result = {31'b0, $signed(a) < $signed(b)};
      alu_op_pkg::SLTU: r.result = {31'b0, a < b};
      // Branches leave the adder sum on the result
      alu_op_pkg::EQ: begin
        r.result     = a - b;
        r.branch_res = a == b;
      end
      alu_op_pkg::NE: begin
        r.result     = a - b;
        r.branch_res = a != b;
      end
      alu_op_pkg::LTS: begin
        r.result     = a + b;
        r.branch_res = $signed(a) < $signed(b);
      end
      alu_op_pkg::LTU: begin
        r.result     = a + b;
        r.branch_res = a < b;
      end
      alu_op_pkg::GES: begin
        r.result     = a + b;
        r.branch_res = $signed(a) >= $signed(b);
      end
      alu_op_pkg::GEU: begin
        r.result     = a + b;
        r.branch_res = a >= b;
      end
      default: begin
        case (op)
          alu_op_pkg::LDPC_MIN:         t = (sa < sb) ? sa : sb;
          alu_op_pkg::LDPC_ABS:         t = (sa < 0) ? -sa : sa;
          alu_op_pkg::LDPC_SUB_SAT:     t = sat127(sa - sb);
          alu_op_pkg::LDPC_ADD_SAT:     t = sat127(sa + sb);
          alu_op_pkg::LDPC_MINMAX: begin
            t = (sa > sb) ? sa : sb;
            t = (sc < t) ? sc : t;
          end
          alu_op_pkg::LDPC_MIN_SORTING: t = (sa == sb) ? sc : sa;
          default:                      t = (b[0] != (sa >= 0)) ? sc : -sc;
        endcase
        r.result = {24'b0, t[7:0]};
      end
    endcase
    return r;
  endfunction

  // ------------------------------
  // Drive and check helpers
  // ------------------------------
  task automatic drive_req(input alu_op_pkg::alu_op_e op, input logic [31:0] a,
      input logic [31:0] b, input logic [31:0] c);
    alu_data_pkg::alu_req_t req;
    req.op        = op;
    req.operand_a = a;
    req.operand_b = b;
    req.imm       = c;
    req_valid_i <= 1'b1;
    req_i       <= req;
  endtask

  task automatic check_eq(input string name, input logic [31:0] want, input logic [31:0] got);
    check_count++;
    assert (got === want) else begin
      $display("FAIL %0t %s expected %h got %h", $time, name, want, got);
      error_count++;
    end
  endtask

  task automatic check_rsp(input alu_data_pkg::alu_rsp_t want);
    check_eq("rsp_valid_o", 32'd1, {31'b0, rsp_valid_o});
    check_eq("rsp_o.result", want.result, rsp_o.result);
    check_eq("rsp_o.branch_res", {31'b0, want.branch_res}, {31'b0, rsp_o.branch_res});
  endtask

  // One strobe and its response one cycle later
  task automatic run_op(input alu_op_pkg::alu_op_e op, input logic [31:0] a,
      input logic [31:0] b, input logic [31:0] c);
    alu_data_pkg::alu_rsp_t want;
    want = expected_rsp(op, a, b, c);
    @(posedge clk_i);
    drive_req(op, a, b, c);
    @(posedge clk_i);
    req_valid_i <= 1'b0;
    @(negedge clk_i);
    check_rsp(want);
  endtask

  task automatic report_test(input string name);
    $display("test %s finished with %0d errors", name, error_count - test_start_errors);
  endtask

  // ------------------------------
  // Directed tests
  // ------------------------------
  task automatic test_arith_logic();
    alu_op_pkg::alu_op_e ops [8] = '{alu_op_pkg::ADD, alu_op_pkg::SUB, alu_op_pkg::ANDL,
        alu_op_pkg::ORL, alu_op_pkg::XORL, alu_op_pkg::ANDN, alu_op_pkg::ORN,
        alu_op_pkg::XNOR};
    test_start_errors = error_count;
    @(negedge clk_i);
    check_eq("rsp_valid_o", 32'd0, {31'b0, rsp_valid_o});
    check_eq("rsp_o.result", 32'd0, rsp_o.result);
    check_eq("rsp_o.branch_res", 32'd0, {31'b0, rsp_o.branch_res});
    foreach (ops[i]) begin
      for (int n = 0; n < 6; n++) begin
        run_op(ops[i], rand32(), rand32(), rand32());
      end
    end
    report_test("arith_logic");
  endtask

  task automatic test_shifts();
    alu_op_pkg::alu_op_e ops [3] = '{alu_op_pkg::SLL, alu_op_pkg::SRL, alu_op_pkg::SRA};
    logic [31:0] b;
    test_start_errors = error_count;
    foreach (ops[i]) begin
      for (int sh = 0; sh < 32; sh++) begin
        // Upper bits of operand_b must not affect the amount
        b = rand32();
        b[4:0] = sh[4:0];
        run_op(ops[i], rand32(), b, rand32());
      end
    end
    report_test("shifts");
  endtask

  task automatic test_compare_branch();
    alu_op_pkg::alu_op_e ops [8] = '{alu_op_pkg::SLTS, alu_op_pkg::SLTU, alu_op_pkg::EQ,
        alu_op_pkg::NE, alu_op_pkg::LTS, alu_op_pkg::LTU, alu_op_pkg::GES, alu_op_pkg::GEU};
    logic [31:0] a;
    test_start_errors = error_count;
    foreach (ops[i]) begin
      for (int n = 0; n < 4; n++) begin
        run_op(ops[i], rand32(), rand32(), rand32());
      end
      for (int n = 0; n < 2; n++) begin
        a = rand32();
        run_op(ops[i], a, a, rand32());
      end
    end
    report_test("compare_branch");
  endtask

  task automatic test_ldpc();
    alu_op_pkg::alu_op_e ops [7] = '{alu_op_pkg::LDPC_MIN, alu_op_pkg::LDPC_ABS,
        alu_op_pkg::LDPC_SUB_SAT, alu_op_pkg::LDPC_ADD_SAT, alu_op_pkg::LDPC_MINMAX,
        alu_op_pkg::LDPC_MIN_SORTING, alu_op_pkg::LDPC_RSIGN_NMESS};
    test_start_errors = error_count;
    // Saturation at both limits
    run_op(alu_op_pkg::LDPC_ADD_SAT, 32'hA5A5A564, 32'h5A5A5A64, 32'h0);
    run_op(alu_op_pkg::LDPC_ADD_SAT, 32'h0000009C, 32'hFFFFFF9C, 32'h0);
    run_op(alu_op_pkg::LDPC_ADD_SAT, 32'h1234567F, 32'h00000000, 32'h0);
    run_op(alu_op_pkg::LDPC_ADD_SAT, 32'h00000081, 32'h000000FF, 32'h0);
    run_op(alu_op_pkg::LDPC_SUB_SAT, 32'h00000064, 32'h0000009C, 32'h0);
    run_op(alu_op_pkg::LDPC_SUB_SAT, 32'hFFFFFF9C, 32'h00000064, 32'h0);
    run_op(alu_op_pkg::LDPC_ABS, 32'h00000080, 32'h0, 32'h0);
    run_op(alu_op_pkg::LDPC_ABS, 32'hCAFE00FB, 32'h0, 32'h0);
    run_op(alu_op_pkg::LDPC_MIN, 32'h00000003, 32'h000000F9, 32'h0);
    run_op(alu_op_pkg::LDPC_MIN_SORTING, 32'h00000005, 32'hFFFF0005, 32'h00000009);
    run_op(alu_op_pkg::LDPC_MIN_SORTING, 32'h00000005, 32'h00000006, 32'h00000009);
    run_op(alu_op_pkg::LDPC_MINMAX, 32'h00000003, 32'h00000009, 32'h00000005);
    run_op(alu_op_pkg::LDPC_MINMAX, 32'h00000003, 32'h00000009, 32'h00000014);
    // Sign restore with a of both signs
    run_op(alu_op_pkg::LDPC_RSIGN_NMESS, 32'h0000000A, 32'h00000000, 32'h00000014);
    run_op(alu_op_pkg::LDPC_RSIGN_NMESS, 32'h0000000A, 32'h00000001, 32'h00000014);
    run_op(alu_op_pkg::LDPC_RSIGN_NMESS, 32'h000000F6, 32'h00000001, 32'h00000014);
    run_op(alu_op_pkg::LDPC_RSIGN_NMESS, 32'h000000F6, 32'h00000000, 32'h00000014);
    foreach (ops[i]) begin
      for (int n = 0; n < 4; n++) begin
        run_op(ops[i], rand32(), rand32(), rand32());
      end
    end
    report_test("ldpc");
  endtask

  task automatic test_back_to_back();
    alu_op_pkg::alu_op_e ops [5] = '{alu_op_pkg::ADD, alu_op_pkg::XORL, alu_op_pkg::SLL,
        alu_op_pkg::LDPC_ADD_SAT, alu_op_pkg::EQ};
    alu_data_pkg::alu_rsp_t want [5];
    logic [31:0] a;
    logic [31:0] b;
    logic [31:0] c;
    test_start_errors = error_count;
    for (int i = 0; i <= 5; i++) begin
      @(posedge clk_i);
      if (i < 5) begin
        a = rand32();
        b = rand32();
        c = rand32();
        want[i] = expected_rsp(ops[i], a, b, c);
        drive_req(ops[i], a, b, c);
      end else begin
        req_valid_i <= 1'b0;
      end
      @(negedge clk_i);
      if (i > 0) begin
        check_rsp(want[i-1]);
      end
    end
    // Idle cycle keeps the last response without valid
    @(posedge clk_i);
    @(negedge clk_i);
    check_eq("rsp_valid_o", 32'd0, {31'b0, rsp_valid_o});
    check_eq("rsp_o.result", want[4].result, rsp_o.result);
    check_eq("rsp_o.branch_res", {31'b0, want[4].branch_res}, {31'b0, rsp_o.branch_res});
    report_test("back_to_back");
  endtask

  // ------------------------------
  // Main sequence and watchdog
  // ------------------------------
  initial begin
    arst_n_i    = 1'b0;
    req_valid_i = 1'b0;
    req_i       = '0;
    repeat (16) @(posedge clk_i);
    arst_n_i <= 1'b1;
    test_arith_logic();
    test_shifts();
    test_compare_branch();
    test_ldpc();
    test_back_to_back();
    $display("tests %0d, checks passed %0d, checks failed %0d", N_TESTS,
             check_count - error_count, error_count);
    if (error_count == 0) begin
      $display("PASS: all tests");
    end else begin
      $display("FAIL: see errors above");
    end
    $finish;
  end

  initial begin
    #(TIMEOUT);
    $display("Timeout, the tests did not finish in the expected time");
    $display("FAIL: see errors above");
    $finish;
  end

endmodule

`default_nettype wire

/* hw/alu_adder.sv */
`default_nettype none

`include "alu_consts.svh"

module alu_adder (
  input  alu_data_pkg::alu_req_t   req_i,
  input  alu_op_pkg::alu_ctrl_t    ctrl_i,
  output alu_data_pkg::adder_res_t res_o
);

  logic [`ALU_XLEN:0]   adder_in_a;
  logic [`ALU_XLEN:0]   adder_in_b;
  logic [`ALU_XLEN:0]   adder_ext;
  logic [`ALU_XLEN-1:0] sum;
  logic                 sign_a;
  logic                 sign_b;

  // Extra LSB carries the +1 of the two's complement
  assign adder_in_a = {req_i.operand_a, 1'b1};
  assign adder_in_b = {req_i.operand_b, 1'b0} ^ {(`ALU_XLEN+1){ctrl_i.negate_b}};

  assign adder_ext = adder_in_a + adder_in_b;
  assign sum       = adder_ext[`ALU_XLEN:1];

  // Sign bits only count for signed compares
  assign sign_a = ctrl_i.signed_cmp & req_i.operand_a[`ALU_XLEN-1];
  assign sign_b = ctrl_i.signed_cmp & req_i.operand_b[`ALU_XLEN-1];

  assign res_o.sum           = sum;
  assign res_o.operand_b_neg = adder_in_b[`ALU_XLEN:1];
  assign res_o.zero          = ~|sum;
  assign res_o.less          = $signed({sign_a, req_i.operand_a})
                             < $signed({sign_b, req_i.operand_b});

endmodule

`default_nettype wire

/* hw/alu_consts.svh */
`ifndef ALU_CONSTS_SVH
`define ALU_CONSTS_SVH

// ------------------------------
// Datapath widths
// ------------------------------
`define ALU_XLEN 32
`define ALU_SHAMT_W 5

// ------------------------------
// LDPC message format
// ------------------------------
`define LDPC_W 8

// Symmetric clamp, negative limit is -LDPC_SAT_MAX
`define LDPC_SAT_MAX 127

`endif

/* hw/alu_data_pkg.sv */
`default_nettype none

`include "alu_consts.svh"

package alu_data_pkg;

  // Incoming request, imm is the third LDPC operand
  typedef struct packed {
    alu_op_pkg::alu_op_e  op;
    logic [`ALU_XLEN-1:0] operand_a;
    logic [`ALU_XLEN-1:0] operand_b;
    logic [`ALU_XLEN-1:0] imm;
  } alu_req_t;

  // Adder outputs shared by result select and branch logic
  typedef struct packed {
    logic [`ALU_XLEN-1:0] sum;
    logic [`ALU_XLEN-1:0] operand_b_neg;
    logic                 zero;
    logic                 less;
  } adder_res_t;

  typedef struct packed {
    logic [`ALU_XLEN-1:0] result;
    logic                 branch_res;
  } alu_rsp_t;

endpackage

`default_nettype wire

/* hw/alu_decoder.sv */
`default_nettype none

module alu_decoder (
  input  alu_op_pkg::alu_op_e   op_i,
  output alu_op_pkg::alu_ctrl_t ctrl_o
);

  always_comb begin
    // Defaults describe a plain ADD
    ctrl_o.negate_b    = 1'b0;
    ctrl_o.signed_cmp  = 1'b0;
    ctrl_o.shift_left  = 1'b0;
    ctrl_o.shift_arith = 1'b0;
    ctrl_o.logic_op    = alu_op_pkg::LOGIC_AND;
    ctrl_o.res_sel     = alu_op_pkg::RES_ADDER;
    ctrl_o.branch_cond = alu_op_pkg::BR_NONE;
    ctrl_o.ldpc_op     = alu_op_pkg::LD_MIN;

    unique case (op_i)
      alu_op_pkg::ADD: ;
      alu_op_pkg::SUB: ctrl_o.negate_b = 1'b1;

      // ------------------------------
      // Bitwise, inverted forms use the negated operand
      // ------------------------------
      alu_op_pkg::ANDL: ctrl_o.res_sel = alu_op_pkg::RES_LOGIC;
      alu_op_pkg::ORL: begin
        ctrl_o.res_sel  = alu_op_pkg::RES_LOGIC;
        ctrl_o.logic_op = alu_op_pkg::LOGIC_OR;
      end
      alu_op_pkg::XORL: begin
        ctrl_o.res_sel  = alu_op_pkg::RES_LOGIC;
        ctrl_o.logic_op = alu_op_pkg::LOGIC_XOR;
      end
      alu_op_pkg::ANDN: begin
        ctrl_o.negate_b = 1'b1;
        ctrl_o.res_sel  = alu_op_pkg::RES_LOGIC;
      end
      alu_op_pkg::ORN: begin
        ctrl_o.negate_b = 1'b1;
        ctrl_o.res_sel  = alu_op_pkg::RES_LOGIC;
        ctrl_o.logic_op = alu_op_pkg::LOGIC_OR;
      end
      alu_op_pkg::XNOR: begin
        ctrl_o.negate_b = 1'b1;
        ctrl_o.res_sel  = alu_op_pkg::RES_LOGIC;
        ctrl_o.logic_op = alu_op_pkg::LOGIC_XOR;
      end

      // Shifts
      alu_op_pkg::SLL: begin
        ctrl_o.res_sel    = alu_op_pkg::RES_SHIFT;
        ctrl_o.shift_left = 1'b1;
      end
      alu_op_pkg::SRL: ctrl_o.res_sel = alu_op_pkg::RES_SHIFT;
      alu_op_pkg::SRA: begin
        ctrl_o.res_sel     = alu_op_pkg::RES_SHIFT;
        ctrl_o.shift_arith = 1'b1;
      end

      // Compares
      alu_op_pkg::SLTS: begin
        ctrl_o.res_sel    = alu_op_pkg::RES_LESS;
        ctrl_o.signed_cmp = 1'b1;
      end
      alu_op_pkg::SLTU: ctrl_o.res_sel = alu_op_pkg::RES_LESS;

      // ------------------------------
      // Branches, EQ and NE test the difference for zero
      // ------------------------------
      alu_op_pkg::EQ: begin
        ctrl_o.negate_b    = 1'b1;
        ctrl_o.branch_cond = alu_op_pkg::BR_EQ;
      end
      alu_op_pkg::NE: begin
        ctrl_o.negate_b    = 1'b1;
        ctrl_o.branch_cond = alu_op_pkg::BR_NE;
      end
      alu_op_pkg::LTS: begin
        ctrl_o.signed_cmp  = 1'b1;
        ctrl_o.branch_cond = alu_op_pkg::BR_LT;
      end
      alu_op_pkg::LTU: ctrl_o.branch_cond = alu_op_pkg::BR_LT;
      alu_op_pkg::GES: begin
        ctrl_o.signed_cmp  = 1'b1;
        ctrl_o.branch_cond = alu_op_pkg::BR_GE;
      end
      alu_op_pkg::GEU: ctrl_o.branch_cond = alu_op_pkg::BR_GE;

      // LDPC
      alu_op_pkg::LDPC_MIN: begin
        ctrl_o.res_sel = alu_op_pkg::RES_LDPC;
      end
      alu_op_pkg::LDPC_ABS: begin
        ctrl_o.res_sel = alu_op_pkg::RES_LDPC;
        ctrl_o.ldpc_op = alu_op_pkg::LD_ABS;
      end
      alu_op_pkg::LDPC_SUB_SAT: begin
        ctrl_o.res_sel = alu_op_pkg::RES_LDPC;
        ctrl_o.ldpc_op = alu_op_pkg::LD_SUB_SAT;
      end
      alu_op_pkg::LDPC_ADD_SAT: begin
        ctrl_o.res_sel = alu_op_pkg::RES_LDPC;
        ctrl_o.ldpc_op = alu_op_pkg::LD_ADD_SAT;
      end
      alu_op_pkg::LDPC_MINMAX: begin
        ctrl_o.res_sel = alu_op_pkg::RES_LDPC;
        ctrl_o.ldpc_op = alu_op_pkg::LD_MINMAX;
      end
      alu_op_pkg::LDPC_MIN_SORTING: begin
        ctrl_o.res_sel = alu_op_pkg::RES_LDPC;
        ctrl_o.ldpc_op = alu_op_pkg::LD_MIN_SORTING;
      end
      alu_op_pkg::LDPC_RSIGN_NMESS: begin
        ctrl_o.res_sel = alu_op_pkg::RES_LDPC;
        ctrl_o.ldpc_op = alu_op_pkg::LD_RSIGN_NMESS;
      end
      default: ;
    endcase
  end

endmodule

`default_nettype wire

/* hw/alu_op_pkg.sv */
`default_nettype none

package alu_op_pkg;

  // Operation code as seen on the request
  typedef enum logic [4:0] {
    ADD, SUB,
    ANDL, ORL, XORL,
    ANDN, ORN, XNOR,
    SLL, SRL, SRA,
    SLTS, SLTU,
    EQ, NE, LTS, LTU, GES, GEU,
    LDPC_MIN, LDPC_ABS, LDPC_SUB_SAT, LDPC_ADD_SAT,
    LDPC_MINMAX, LDPC_MIN_SORTING, LDPC_RSIGN_NMESS
  } alu_op_e;

  // Which unit drives the result
  typedef enum logic [2:0] {
    RES_ADDER, RES_LOGIC, RES_SHIFT, RES_LESS, RES_LDPC
  } res_sel_e;

  typedef enum logic [1:0] {
    LOGIC_AND, LOGIC_OR, LOGIC_XOR
  } logic_op_e;

  typedef enum logic [2:0] {
    BR_NONE, BR_EQ, BR_NE, BR_LT, BR_GE
  } branch_cond_e;

  typedef enum logic [2:0] {
    LD_MIN, LD_ABS, LD_SUB_SAT, LD_ADD_SAT, LD_MINMAX, LD_MIN_SORTING, LD_RSIGN_NMESS
  } ldpc_op_e;

  typedef struct packed {
    logic         negate_b;
    logic         signed_cmp;
    logic         shift_left;
    logic         shift_arith;
    logic_op_e    logic_op;
    res_sel_e     res_sel;
    branch_cond_e branch_cond;
    ldpc_op_e     ldpc_op;
  } alu_ctrl_t;

endpackage

`default_nettype wire

/* hw/alu_result_stage.sv */
`default_nettype none

`include "alu_consts.svh"

module alu_result_stage (
  input  logic                     clk_i,
  input  logic                     arst_n_i,
  input  logic                     valid_i,
  input  alu_op_pkg::alu_ctrl_t    ctrl_i,
  input  logic [`ALU_XLEN-1:0]     operand_a_i,
  input  alu_data_pkg::adder_res_t adder_i,
  input  logic [`ALU_XLEN-1:0]     shift_i,
  input  logic [`ALU_XLEN-1:0]     ldpc_i,
  output logic                     valid_o,
  output alu_data_pkg::alu_rsp_t   rsp_o
);

  logic [`ALU_XLEN-1:0] logic_res;
  logic [`ALU_XLEN-1:0] result_d;
  logic                 branch_d;

  // ------------------------------
  // Bitwise ops on the possibly inverted operand
  // ------------------------------
  always_comb begin
    unique case (ctrl_i.logic_op)
      alu_op_pkg::LOGIC_OR:  logic_res = operand_a_i | adder_i.operand_b_neg;
      alu_op_pkg::LOGIC_XOR: logic_res = operand_a_i ^ adder_i.operand_b_neg;
      default:               logic_res = operand_a_i & adder_i.operand_b_neg;
    endcase
  end

  always_comb begin
    unique case (ctrl_i.res_sel)
      alu_op_pkg::RES_LOGIC: result_d = logic_res;
      alu_op_pkg::RES_SHIFT: result_d = shift_i;
      alu_op_pkg::RES_LESS:  result_d = {{(`ALU_XLEN-1){1'b0}}, adder_i.less};
      alu_op_pkg::RES_LDPC:  result_d = ldpc_i;
      default:               result_d = adder_i.sum;
    endcase
  end

  // Branch outcome, taken for anything that is not a branch
  always_comb begin
    unique case (ctrl_i.branch_cond)
      alu_op_pkg::BR_EQ: branch_d = adder_i.zero;
      alu_op_pkg::BR_NE: branch_d = ~adder_i.zero;
      alu_op_pkg::BR_LT: branch_d = adder_i.less;
      alu_op_pkg::BR_GE: branch_d = ~adder_i.less;
      default:           branch_d = 1'b1;
    endcase
  end

  // ------------------------------
  // Output register
  // ------------------------------
  always_ff @(posedge clk_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      valid_o <= 1'b0;
      rsp_o   <= '0;
    end else begin
      valid_o <= valid_i;
      if (valid_i) begin
        rsp_o.result     <= result_d;
        rsp_o.branch_res <= branch_d;
      end
    end
  end

endmodule

`default_nettype wire

/* hw/alu_shifter.sv */
`default_nettype none

`include "alu_consts.svh"

module alu_shifter (
  input  logic [`ALU_XLEN-1:0]    operand_i,
  input  logic [`ALU_SHAMT_W-1:0] shamt_i,
  input  alu_op_pkg::alu_ctrl_t   ctrl_i,
  output logic [`ALU_XLEN-1:0]    result_o
);

  logic [`ALU_XLEN-1:0] shift_in;
  logic [`ALU_XLEN:0]   shift_ext;
  logic [`ALU_XLEN:0]   right_ext;

  function automatic logic [`ALU_XLEN-1:0] bit_rev(input logic [`ALU_XLEN-1:0] val);
    logic [`ALU_XLEN-1:0] rev;
    for (int i = 0; i < `ALU_XLEN; i++) begin
      rev[i] = val[`ALU_XLEN-1-i];
    end
    return rev;
  endfunction

  // Left shift is a right shift of the reversed word
  assign shift_in = ctrl_i.shift_left ? bit_rev(operand_i) : operand_i;

  // Fill bit is zero unless SRA
  assign shift_ext = {ctrl_i.shift_arith & shift_in[`ALU_XLEN-1], shift_in};
  assign right_ext = $unsigned($signed(shift_ext) >>> shamt_i);

  assign result_o = ctrl_i.shift_left ? bit_rev(right_ext[`ALU_XLEN-1:0])
                                      : right_ext[`ALU_XLEN-1:0];

endmodule

`default_nettype wire

/* hw/alu_top.sv */
`default_nettype none

`include "alu_consts.svh"

module alu_top (
  input  logic                   clk_i,
  input  logic                   arst_n_i,
  input  logic                   req_valid_i,
  input  alu_data_pkg::alu_req_t req_i,
  output logic                   rsp_valid_o,
  output alu_data_pkg::alu_rsp_t rsp_o
);

  alu_op_pkg::alu_ctrl_t    ctrl;
  alu_data_pkg::adder_res_t adder_res;
  logic [`ALU_XLEN-1:0]     shift_res;
  logic [`ALU_XLEN-1:0]     ldpc_res;

  alu_decoder u_decoder (
    .op_i   (req_i.op),
    .ctrl_o (ctrl)
  );

  alu_adder u_adder (
    .req_i  (req_i),
    .ctrl_i (ctrl),
    .res_o  (adder_res)
  );

  // Shift amount comes from the low bits of operand_b
  alu_shifter u_shifter (
    .operand_i (req_i.operand_a),
    .shamt_i   (req_i.operand_b[`ALU_SHAMT_W-1:0]),
    .ctrl_i    (ctrl),
    .result_o  (shift_res)
  );

  ldpc_unit u_ldpc (
    .req_i    (req_i),
    .ctrl_i   (ctrl),
    .result_o (ldpc_res)
  );

  alu_result_stage u_result_stage (
    .clk_i       (clk_i),
    .arst_n_i    (arst_n_i),
    .valid_i     (req_valid_i),
    .ctrl_i      (ctrl),
    .operand_a_i (req_i.operand_a),
    .adder_i     (adder_res),
    .shift_i     (shift_res),
    .ldpc_i      (ldpc_res),
    .valid_o     (rsp_valid_o),
    .rsp_o       (rsp_o)
  );

endmodule

`default_nettype wire

/* hw/ldpc_unit.sv */
`default_nettype none

`include "alu_consts.svh"

module ldpc_unit (
  input  alu_data_pkg::alu_req_t  req_i,
  input  alu_op_pkg::alu_ctrl_t   ctrl_i,
  output logic [`ALU_XLEN-1:0]    result_o
);

  localparam int W = `LDPC_W;
  localparam logic signed [W-1:0] SAT_POS = W'(`LDPC_SAT_MAX);
  localparam logic signed [W-1:0] SAT_NEG = W'(-`LDPC_SAT_MAX);

  logic signed [W-1:0] a;
  logic signed [W-1:0] b;
  logic signed [W-1:0] c;
  logic signed [W:0]   sum9;
  logic signed [W:0]   diff9;
  logic                a_ge_b;
  logic [W-1:0]        max_ab;
  logic                keep_sign;
  logic [W-1:0]        ldpc_res;

  function automatic logic [W-1:0] sat9(input logic signed [W:0] val);
    if (val > SAT_POS) begin
      return SAT_POS;
    end else if (val < SAT_NEG) begin
      return SAT_NEG;
    end
    return val[W-1:0];
  endfunction

  assign a = req_i.operand_a[W-1:0];
  assign b = req_i.operand_b[W-1:0];
  assign c = req_i.imm[W-1:0];

  // One extra bit keeps the overflow visible
  assign sum9  = {a[W-1], a} + {b[W-1], b};
  assign diff9 = {a[W-1], a} - {b[W-1], b};

  assign a_ge_b = a >= b;
  assign max_ab = a_ge_b ? a : b;

  // Keep c when b[0] disagrees with a >= 0
  assign keep_sign = b[0] ^ ~a[W-1];

  always_comb begin
    unique case (ctrl_i.ldpc_op)
      alu_op_pkg::LD_MIN:         ldpc_res = a_ge_b ? b : a;
      alu_op_pkg::LD_ABS:         ldpc_res = a[W-1] ? -a : a;
      alu_op_pkg::LD_SUB_SAT:     ldpc_res = sat9(diff9);
      alu_op_pkg::LD_ADD_SAT:     ldpc_res = sat9(sum9);
      alu_op_pkg::LD_MINMAX:      ldpc_res = (c >= $signed(max_ab)) ? max_ab : c;
      alu_op_pkg::LD_MIN_SORTING: ldpc_res = (a == b) ? c : a;
      alu_op_pkg::LD_RSIGN_NMESS: ldpc_res = keep_sign ? c : -c;
      default:                    ldpc_res = '0;
    endcase
  end

  assign result_o = {{(`ALU_XLEN-W){1'b0}}, ldpc_res};

endmodule

`default_nettype wire
